//--- pagerank_cu_control.f
hdl/cu_ctrl_pkg.sv
hdl/cmd_arbiter.sv
hdl/cmd_burst_buffer.sv
hdl/response_router.sv
hdl/pagerank_cu_control.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/pagerank_cu_control_assert.sv
testbench/tb_pagerank_cu_control.sv

//--- Bender.yml
package:
  name: pagerank_cu_control

sources:
  - hdl/cu_ctrl_pkg.sv
  - hdl/cmd_arbiter.sv
  - hdl/cmd_burst_buffer.sv
  - hdl/response_router.sv
  - hdl/pagerank_cu_control.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_checker.sv
      - testbench/pagerank_cu_control_assert.sv
      - testbench/tb_pagerank_cu_control.sv

//--- testbench/tb_pagerank_cu_control.sv
`timescale 1ns/1ps

module tb_pagerank_cu_control;

	// One row of the stimulus table
	typedef struct packed {
		logic [8*12-1:0]                   name;
		logic [cu_ctrl_pkg::NUM_CU-1:0]    mask;
		int                                rounds;
		logic [cu_ctrl_pkg::ADDR_BITS-1:0] addr_base;
		logic [cu_ctrl_pkg::SIZE_BITS-1:0] size;
		int                                alfull_hold;
		int                                responses;
		int                                disable_cycles;
	} test_row_t;

	logic                           clock;
	logic                           rstn;
	logic                           enabled_in;
	cu_ctrl_pkg::cu_command_t       cu_command [cu_ctrl_pkg::NUM_CU];
	logic [cu_ctrl_pkg::NUM_CU-1:0] cu_request;
	logic [cu_ctrl_pkg::NUM_CU-1:0] cu_ready;
	cu_ctrl_pkg::read_command_t     command_out;
	logic                           bus_request;
	logic                           bus_grant;
	logic                           host_alfull;
	cu_ctrl_pkg::read_response_t    response_in;
	cu_ctrl_pkg::read_response_t    response_cu_out [cu_ctrl_pkg::NUM_CU];

	test_row_t   tests [9];
	int          cur_test;
	int          next_cu;
	int          round_idx [cu_ctrl_pkg::NUM_CU];
	int          cycle_count = 0;
	int          cycle_limit = 0;
	logic [31:0] lfsr_state;

	tb_clock_gen u_clock (.clock(clock), .rstn(rstn));

	pagerank_cu_control uut (
		.clock          (clock),
		.rstn           (rstn),
		.enabled_in     (enabled_in),
		.cu_command     (cu_command),
		.cu_request     (cu_request),
		.cu_ready       (cu_ready),
		.command_out    (command_out),
		.bus_request    (bus_request),
		.bus_grant      (bus_grant),
		.host_alfull    (host_alfull),
		.response_in    (response_in),
		.response_cu_out(response_cu_out)
	);

	tb_checker chk (
		.clock          (clock),
		.rstn           (rstn),
		.enabled_in     (enabled_in),
		.cu_ready       (cu_ready),
		.command_out    (command_out),
		.bus_request    (bus_request),
		.response_in    (response_in),
		.response_cu_out(response_cu_out)
	);

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic take_random(input int nbits, output logic [31:0] value);
		value = '0;
		for (int b = 0; b < nbits; b++) begin
			lfsr_state = lfsr_next(lfsr_state);
			value      = {value[30:0], lfsr_state[0]};
		end
	endtask

	function automatic cu_ctrl_pkg::cu_command_t make_command(input int t, input int cu, input int r);
		cu_ctrl_pkg::cu_command_t c;
		c.address = tests[t].addr_base + 32'(cu) * 32'h1000 + 32'(r) * 32'h40;
		c.size    = tests[t].size + 8'(cu);
		return c;
	endfunction

	// CU models, next command right after each take
	always @(posedge clock) begin
		for (int i = 0; i < cu_ctrl_pkg::NUM_CU; i++) begin
			if (cu_request[i] && cu_ready[i]) begin
				round_idx[i] = round_idx[i] + 1;
				if (round_idx[i] < tests[cur_test].rounds) begin
					cu_command[i] <= make_command(cur_test, i, round_idx[i]);
				end else begin
					cu_request[i] <= 1'b0;
				end
			end
		end
	end

	// Host grants one cycle after it sees a request
	always @(posedge clock) begin
		if (!rstn || bus_grant) begin
			bus_grant <= 1'b0;
		end else begin
			bus_grant <= bus_request && !host_alfull;
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Run stopped after %0d cycles with tests still running", cycle_count);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic run_test(input int t);
		test_row_t                  row;
		cu_ctrl_pkg::cu_command_t   c;
		cu_ctrl_pkg::read_command_t cmd;
		logic [31:0]                id_bits;
		logic [31:0]                tag_bits;
		int                         cu;
		int                         drain_limit;
		int                         wait_cycles;
		row = tests[t];
		drain_limit = $countones(row.mask) * row.rounds * 8 + row.responses + 20;
		chk.start_test(string'(row.name));
		@(posedge clock);
		if (row.disable_cycles > 0) begin
			enabled_in <= 1'b0;
			repeat (3) @(posedge clock);
			chk.set_ready_blocked(1'b1);
		end
		host_alfull <= (row.alfull_hold > 0);
		// Take order is round robin from the CU after the last one taken
		for (int r = 0; r < row.rounds; r++) begin
			for (int off = 0; off < cu_ctrl_pkg::NUM_CU; off++) begin
				cu = (next_cu + off) % cu_ctrl_pkg::NUM_CU;
				if (row.mask[cu]) begin
					c   = make_command(t, cu, r);
					cmd = '{valid: 1'b1, cu_id: cu_ctrl_pkg::cu_id_t'(cu), address: c.address,
						size: c.size};
					chk.expect_command(cmd);
				end
			end
		end
		for (int i = 0; i < cu_ctrl_pkg::NUM_CU; i++) begin
			round_idx[i] = 0;
			if (row.mask[i] && row.rounds > 0) begin
				cu_request[i] <= 1'b1;
				cu_command[i] <= make_command(t, i, 0);
			end
		end
		// Last CU taken is the last masked one before the start point
		for (int off = 0; off < cu_ctrl_pkg::NUM_CU; off++) begin
			if (row.rounds > 0 && row.mask[(next_cu + off) % cu_ctrl_pkg::NUM_CU]) begin
				cu = (next_cu + off) % cu_ctrl_pkg::NUM_CU;
			end
		end
		if (row.rounds > 0 && row.mask != '0) begin
			next_cu = (cu + 1) % cu_ctrl_pkg::NUM_CU;
		end
		for (int n = 0; n < row.responses; n++) begin
			take_random(cu_ctrl_pkg::CU_ID_BITS, id_bits);
			take_random(cu_ctrl_pkg::TAG_BITS, tag_bits);
			@(posedge clock);
			response_in <= '{valid: 1'b1, cu_id: id_bits[1:0], tag: tag_bits[7:0]};
		end
		@(posedge clock);
		response_in <= '0;
		if (row.alfull_hold > 0) begin
			repeat (row.alfull_hold) @(posedge clock);
			@(negedge clock);
			chk.check_ready_blocked();
			@(posedge clock);
			host_alfull <= 1'b0;
		end
		if (row.disable_cycles > 0) begin
			repeat (row.disable_cycles) @(posedge clock);
			chk.set_ready_blocked(1'b0);
			enabled_in <= 1'b1;
		end
		// Drain with a bound, leftovers are reported by the checker
		@(negedge clock);
		wait_cycles = 0;
		while ((cu_request != '0 || chk.busy()) && wait_cycles < drain_limit) begin
			@(negedge clock);
			wait_cycles++;
		end
		repeat (4) @(negedge clock);
		chk.end_test();
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		enabled_in  = 1'b0;
		cu_request  = '0;
		bus_grant   = 1'b0;
		host_alfull = 1'b0;
		response_in = '0;
		lfsr_state  = 32'h8522cdb0;
		cur_test    = 0;
		next_cu     = 0;
		for (int i = 0; i < cu_ctrl_pkg::NUM_CU; i++) begin
			cu_command[i] = '0;
			round_idx[i]  = 0;
		end
		// name, mask, rounds, address base, size, host_alfull hold, responses, disabled cycles
		tests[0] = '{"single_cu0", 4'b0001, 1, 32'h1000_0000, 8'h10, 0, 0, 0};
		tests[1] = '{"single_cu1", 4'b0010, 1, 32'h1100_0000, 8'h11, 0, 0, 0};
		tests[2] = '{"single_cu2", 4'b0100, 1, 32'h1200_0000, 8'h12, 0, 0, 0};
		tests[3] = '{"single_cu3", 4'b1000, 1, 32'h1300_0000, 8'h13, 0, 0, 0};
		tests[4] = '{"all_four", 4'b1111, 1, 32'h2000_0000, 8'h20, 0, 0, 0};
		tests[5] = '{"host_alfull", 4'b1111, 5, 32'h3000_0000, 8'h30, 40, 0, 0};
		tests[6] = '{"responses", 4'b0000, 0, 32'h0000_0000, 8'h00, 0, 12, 0};
		tests[7] = '{"disabled", 4'b1111, 1, 32'h4000_0000, 8'h40, 0, 4, 12};
		tests[8] = '{"re_enabled", 4'b1111, 2, 32'h5000_0000, 8'h50, 0, 6, 0};
		// Reset and idle check, then each test in turn
		cycle_limit = 40;
		for (int t = 0; t < $size(tests); t++) begin
			cycle_limit += $countones(tests[t].mask) * tests[t].rounds * 8 + tests[t].responses + 20;
		end
		wait (rstn === 1'b1);
		repeat (2) @(posedge clock);
		@(negedge clock);
		chk.start_test("reset_state");
		chk.check_idle();
		chk.end_test();
		@(posedge clock);
		enabled_in <= 1'b1;
		repeat (2) @(posedge clock);
		for (int t = 0; t < $size(tests); t++) begin
			cur_test = t;
			run_test(t);
		end
		chk.print_summary(uut.u_assert.failures);
		if (chk.error_count == 0 && uut.u_assert.failures == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- testbench/pagerank_cu_control_assert.sv
`timescale 1ns/1ps

module pagerank_cu_control_assert (
	input logic                           clock,
	input logic                           rstn,
	input logic                           enabled,
	input logic [cu_ctrl_pkg::NUM_CU-1:0] cu_ready,
	input cu_ctrl_pkg::read_command_t     command_out,
	input logic                           bus_request,
	input logic                           bus_grant,
	input logic                           host_alfull,
	input cu_ctrl_pkg::read_response_t    response_in,
	input cu_ctrl_pkg::read_response_t    response_cu_out [cu_ctrl_pkg::NUM_CU]
);

	int failures = 0;

	a_one_ready: assert property (@(posedge clock) disable iff (!rstn) $onehot0(cu_ready))
		else begin
			$error("more than one cu_ready bit high: %b", cu_ready);
			failures++;
		end

	// Pop at the grant edge, head register, then output register
	a_out_after_grant: assert property (@(posedge clock) disable iff (!rstn)
		command_out.valid |-> $past(bus_grant && bus_request, 2))
		else begin
			$error("command_out valid without a grant two cycles before");
			failures++;
		end

	a_alfull_stops_request: assert property (@(posedge clock) disable iff (!rstn)
		$past(host_alfull) |-> !bus_request)
		else begin
			$error("bus_request high one cycle after host_alfull");
			failures++;
		end

	for (genvar i = 0; i < cu_ctrl_pkg::NUM_CU; i++) begin : g_route
		a_route: assert property (@(posedge clock) disable iff (!rstn)
			(enabled && response_in.valid && response_in.cu_id == cu_ctrl_pkg::cu_id_t'(i))
			|-> ##2 (response_cu_out[i].valid && response_cu_out[i].tag == $past(response_in.tag, 2)))
			else begin
				$error("response for CU %0d missing or tag changed", i);
				failures++;
			end
	end

endmodule

bind pagerank_cu_control pagerank_cu_control_assert u_assert (
	.clock          (clock),
	.rstn           (rstn),
	.enabled        (enabled),
	.cu_ready       (cu_ready),
	.command_out    (command_out),
	.bus_request    (bus_request),
	.bus_grant      (bus_grant),
	.host_alfull    (host_alfull),
	.response_in    (response_in),
	.response_cu_out(response_cu_out)
);

//--- testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
	input logic                           clock,
	input logic                           rstn,
	input logic                           enabled_in,
	input logic [cu_ctrl_pkg::NUM_CU-1:0] cu_ready,
	input cu_ctrl_pkg::read_command_t     command_out,
	input logic                           bus_request,
	input cu_ctrl_pkg::read_response_t    response_in,
	input cu_ctrl_pkg::read_response_t    response_cu_out [cu_ctrl_pkg::NUM_CU]
);

	string test_name     = "none";
	int    error_count   = 0;
	int    test_errors   = 0;
	int    test_count    = 0;
	int    cycle         = 0;
	logic  ready_blocked = 1'b0;
	logic  enabled_model;
	logic  due_now;
	logic  want_valid;

	cu_ctrl_pkg::read_command_t  want_cmd;
	cu_ctrl_pkg::read_response_t want_resp;

	// Commands in take order, responses with the cycle they must show up
	cu_ctrl_pkg::read_command_t  expected_cmds [$];
	int                          resp_due [$];
	cu_ctrl_pkg::read_response_t resp_expected [$];

	task automatic report(input string what, input logic [63:0] expected, input logic [63:0] actual);
		$display("[FAIL] %s: %s expected %0h actual %0h", test_name, what, expected, actual);
		error_count++;
		test_errors++;
	endtask

	task automatic start_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic expect_command(input cu_ctrl_pkg::read_command_t cmd);
		expected_cmds.push_back(cmd);
	endtask

	task automatic set_ready_blocked(input logic value);
		ready_blocked = value;
	endtask

	function automatic logic busy();
		return (expected_cmds.size() != 0) || (resp_due.size() != 0);
	endfunction

	task automatic check_idle();
		if (cu_ready !== '0) begin
			report("cu_ready", '0, cu_ready);
		end
		if (bus_request !== 1'b0) begin
			report("bus_request", 0, bus_request);
		end
		if (command_out.valid !== 1'b0) begin
			report("command_out.valid", 0, command_out.valid);
		end
		for (int i = 0; i < cu_ctrl_pkg::NUM_CU; i++) begin
			if (response_cu_out[i].valid !== 1'b0) begin
				report($sformatf("response_cu_out[%0d].valid", i), 0, response_cu_out[i].valid);
			end
		end
	endtask

	// Buffer almost full and host stalled
	task automatic check_ready_blocked();
		if (cu_ready !== '0) begin
			report("cu_ready with buffer almost full", '0, cu_ready);
		end
		if (bus_request !== 1'b0) begin
			report("bus_request under host_alfull", 0, bus_request);
		end
	endtask

	task automatic end_test();
		if (expected_cmds.size() != 0) begin
			$display("[FAIL] %s: %0d commands never came out on command_out", test_name,
				expected_cmds.size());
			error_count++;
			test_errors++;
			expected_cmds.delete();
		end
		test_count++;
		$display("test %s finished with %0d errors", test_name, test_errors);
	endtask

	task automatic print_summary(input int assert_failures);
		$display("%0d tests, %0d check errors, %0d assertion failures", test_count, error_count,
			assert_failures);
	endtask

	//////////////////////////////
	// Port monitor
	//////////////////////////////

	always @(posedge clock) begin
		if (!rstn) begin
			enabled_model <= 1'b0;
		end else begin
			// Registered enable inside the DUT
			enabled_model <= enabled_in;
			if (ready_blocked && cu_ready !== '0) begin
				report("cu_ready while disabled", '0, cu_ready);
			end
			if (command_out.valid) begin
				if (expected_cmds.size() == 0) begin
					report("unexpected command_out", '0, command_out);
				end else begin
					want_cmd = expected_cmds.pop_front();
					if (command_out !== want_cmd) begin
						report("command_out", want_cmd, command_out);
					end
				end
			end
			due_now   = (resp_due.size() != 0) && (resp_due[0] == cycle);
			want_resp = due_now ? resp_expected[0] : '0;
			for (int i = 0; i < cu_ctrl_pkg::NUM_CU; i++) begin
				want_valid = due_now && (want_resp.cu_id == cu_ctrl_pkg::cu_id_t'(i));
				if (response_cu_out[i].valid !== want_valid) begin
					report($sformatf("response_cu_out[%0d].valid", i), want_valid,
						response_cu_out[i].valid);
				end else if (want_valid && response_cu_out[i] !== want_resp) begin
					report($sformatf("response_cu_out[%0d]", i), want_resp,
						response_cu_out[i]);
				end
			end
			if (due_now) begin
				void'(resp_due.pop_front());
				void'(resp_expected.pop_front());
			end
			// Two register stages, dropped while disabled
			if (enabled_model && response_in.valid) begin
				resp_due.push_back(cycle + 2);
				resp_expected.push_back(response_in);
			end
			cycle++;
		end
	end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock,
	output logic rstn
);

	// 20 ns period
	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// Reset held low over the first four rising edges
	initial begin
		rstn = 1'b0;
		repeat (4) @(posedge clock);
		rstn <= 1'b1;
	end

endmodule

//--- hdl/pagerank_cu_control.sv
`timescale 1ns/1ps

module pagerank_cu_control (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled_in,
	input  cu_ctrl_pkg::cu_command_t    cu_command [cu_ctrl_pkg::NUM_CU],
	input  logic [cu_ctrl_pkg::NUM_CU-1:0] cu_request,
	output logic [cu_ctrl_pkg::NUM_CU-1:0] cu_ready,
	output cu_ctrl_pkg::read_command_t  command_out,
	output logic                        bus_request,
	input  logic                        bus_grant,
	input  logic                        host_alfull,
	input  cu_ctrl_pkg::read_response_t response_in,
	output cu_ctrl_pkg::read_response_t response_cu_out [cu_ctrl_pkg::NUM_CU]
);

	logic                       enabled;
	logic                       buffer_alfull;
	cu_ctrl_pkg::read_command_t arb_command;

	// Enable seen by every stage one cycle after the pin
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled <= 1'b0;
		end else begin
			enabled <= enabled_in;
		end
	end

	//////////////////////////////
	// Command path
	//////////////////////////////

	cmd_arbiter u_cmd_arbiter (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled),
		.cu_command   (cu_command),
		.cu_request   (cu_request),
		.cu_ready     (cu_ready),
		.buffer_alfull(buffer_alfull),
		.arb_command  (arb_command)
	);

	cmd_burst_buffer u_cmd_burst_buffer (
		.clock        (clock),
		.rstn         (rstn),
		.enabled      (enabled),
		.arb_command  (arb_command),
		.buffer_alfull(buffer_alfull),
		.bus_request  (bus_request),
		.bus_grant    (bus_grant),
		.host_alfull  (host_alfull),
		.command_out  (command_out)
	);

	//////////////////////////////
	// Response path
	//////////////////////////////

	response_router u_response_router (
		.clock          (clock),
		.rstn           (rstn),
		.enabled        (enabled),
		.response_in    (response_in),
		.response_cu_out(response_cu_out)
	);

endmodule

//--- hdl/response_router.sv
`timescale 1ns/1ps

module response_router (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        enabled,
	input  cu_ctrl_pkg::read_response_t response_in,
	output cu_ctrl_pkg::read_response_t response_cu_out [cu_ctrl_pkg::NUM_CU]
);

	// First stage
	logic                             in_valid;
	cu_ctrl_pkg::cu_id_t              in_id;
	logic [cu_ctrl_pkg::TAG_BITS-1:0] in_tag;

	// Second stage, one copy per CU
	logic [cu_ctrl_pkg::NUM_CU-1:0]   out_valid;
	cu_ctrl_pkg::cu_id_t              out_id  [cu_ctrl_pkg::NUM_CU];
	logic [cu_ctrl_pkg::TAG_BITS-1:0] out_tag [cu_ctrl_pkg::NUM_CU];

	// Responses seen while disabled are dropped here
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			in_valid <= 1'b0;
		end else begin
			in_valid <= enabled && response_in.valid;
		end
	end

	always_ff @(posedge clock) begin
		in_id  <= response_in.cu_id;
		in_tag <= response_in.tag;
	end

	//////////////////////////////
	// Route by cu_id
	//////////////////////////////

	for (genvar i = 0; i < cu_ctrl_pkg::NUM_CU; i++) begin : g_route
		always_ff @(posedge clock or negedge rstn) begin
			if (!rstn) begin
				out_valid[i] <= 1'b0;
			end else begin
				out_valid[i] <= in_valid && (in_id == cu_ctrl_pkg::cu_id_t'(i));
			end
		end

		always_ff @(posedge clock) begin
			out_id[i]  <= in_id;
			out_tag[i] <= in_tag;
		end

		assign response_cu_out[i] = '{valid: out_valid[i], cu_id: out_id[i], tag: out_tag[i]};
	end

endmodule

//--- hdl/cmd_burst_buffer.sv
`timescale 1ns/1ps

module cmd_burst_buffer (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enabled,
	input  cu_ctrl_pkg::read_command_t arb_command,
	output logic                       buffer_alfull,
	output logic                       bus_request,
	input  logic                       bus_grant,
	input  logic                       host_alfull,
	output cu_ctrl_pkg::read_command_t command_out
);

	cu_ctrl_pkg::read_command_t mem [cu_ctrl_pkg::CMD_BUFFER_DEPTH];

	logic [cu_ctrl_pkg::CMD_PTR_BITS-1:0]   wr_ptr;
	logic [cu_ctrl_pkg::CMD_PTR_BITS-1:0]   rd_ptr;
	logic [cu_ctrl_pkg::CMD_COUNT_BITS-1:0] fill_count;
	logic [cu_ctrl_pkg::CMD_COUNT_BITS-1:0] count_next;
	logic                                   push;
	logic                                   pop;

	// Popped head, then the output stage
	logic                       head_valid;
	cu_ctrl_pkg::read_command_t head_entry;
	logic                       out_valid;
	cu_ctrl_pkg::read_command_t out_entry;

	//////////////////////////////
	// FIFO control
	//////////////////////////////

	assign push = arb_command.valid;
	assign pop  = bus_grant && (fill_count != '0);

	always_comb begin
		count_next = fill_count;
		if (push && !pop) begin
			count_next = fill_count + 1'b1;
		end else if (pop && !push) begin
			count_next = fill_count - 1'b1;
		end
	end

	assign buffer_alfull = (fill_count >= cu_ctrl_pkg::CMD_BUFFER_ALFULL);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			fill_count  <= '0;
			bus_request <= 1'b0;
			head_valid  <= 1'b0;
			out_valid   <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			fill_count <= count_next;
			// Request only for entries left after this edge's pop
			bus_request <= (count_next != '0) && !host_alfull && enabled;
			head_valid  <= pop;
			out_valid   <= head_valid;
		end
	end

	//////////////////////////////
	// Storage
	//////////////////////////////

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= arb_command;
		end
		if (pop) begin
			head_entry <= mem[rd_ptr];
		end
		out_entry <= head_entry;
	end

	assign command_out = '{
		valid:   out_valid,
		cu_id:   out_entry.cu_id,
		address: out_entry.address,
		size:    out_entry.size
	};

endmodule

//--- hdl/cmd_arbiter.sv
`timescale 1ns/1ps

module cmd_arbiter (
	input  logic                       clock,
	input  logic                       rstn,
	input  logic                       enabled,
	input  cu_ctrl_pkg::cu_command_t   cu_command [cu_ctrl_pkg::NUM_CU],
	input  logic [cu_ctrl_pkg::NUM_CU-1:0] cu_request,
	output logic [cu_ctrl_pkg::NUM_CU-1:0] cu_ready,
	input  logic                       buffer_alfull,
	output cu_ctrl_pkg::read_command_t arb_command
);

	logic [cu_ctrl_pkg::NUM_CU-1:0] take;
	logic [cu_ctrl_pkg::NUM_CU-1:0] candidates;
	logic [cu_ctrl_pkg::NUM_CU-1:0] ready_next;
	logic                           take_any;
	logic                           found;
	cu_ctrl_pkg::cu_id_t            take_id;
	cu_ctrl_pkg::cu_id_t            rr_ptr;
	cu_ctrl_pkg::cu_id_t            next_ptr;
	cu_ctrl_pkg::cu_id_t            rr_idx;

	// Output register, payload kept apart from valid
	logic                     arb_valid;
	cu_ctrl_pkg::cu_id_t      arb_id;
	cu_ctrl_pkg::cu_command_t arb_payload;

	//////////////////////////////
	// Take detection
	//////////////////////////////

	// At most one ready bit is high, so at most one take
	assign take     = cu_request & cu_ready;
	assign take_any = |take;

	always_comb begin
		take_id = '0;
		for (int i = 0; i < cu_ctrl_pkg::NUM_CU; i++) begin
			if (take[i]) begin
				take_id = cu_ctrl_pkg::cu_id_t'(i);
			end
		end
	end

	//////////////////////////////
	// Round-robin pick
	//////////////////////////////

	// Search starts just after the last CU taken
	assign next_ptr = take_any ? cu_ctrl_pkg::cu_id_t'((take_id + 1) % cu_ctrl_pkg::NUM_CU)
		: rr_ptr;

	// The CU taken at this edge still shows its request, so mask it out
	assign candidates = (enabled && !buffer_alfull) ? (cu_request & ~take) : '0;

	always_comb begin
		ready_next = '0;
		found      = 1'b0;
		rr_idx     = next_ptr;
		for (int off = 0; off < cu_ctrl_pkg::NUM_CU; off++) begin
			rr_idx = cu_ctrl_pkg::cu_id_t'((next_ptr + off) % cu_ctrl_pkg::NUM_CU);
			if (!found && candidates[rr_idx]) begin
				ready_next[rr_idx] = 1'b1;
				found              = 1'b1;
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_ready  <= '0;
			rr_ptr    <= '0;
			arb_valid <= 1'b0;
		end else begin
			cu_ready  <= ready_next;
			rr_ptr    <= next_ptr;
			arb_valid <= take_any;
		end
	end

	// Stamp the taker's index onto its command
	always_ff @(posedge clock) begin
		if (take_any) begin
			arb_id      <= take_id;
			arb_payload <= cu_command[take_id];
		end
	end

	assign arb_command = '{
		valid:   arb_valid,
		cu_id:   arb_id,
		address: arb_payload.address,
		size:    arb_payload.size
	};

endmodule

//--- hdl/cu_ctrl_pkg.sv
package cu_ctrl_pkg;

	//////////////////////////////
	// Sizes
	//////////////////////////////

	// Compute units sharing the host read port
	localparam int NUM_CU     = 4;
	localparam int CU_ID_BITS = 2;

	localparam int ADDR_BITS = 32;
	localparam int SIZE_BITS = 8;
	localparam int TAG_BITS  = 8;

	// Burst buffer geometry
	localparam int CMD_BUFFER_DEPTH  = 16;
	localparam int CMD_BUFFER_ALFULL = 14;
	localparam int CMD_PTR_BITS      = $clog2(CMD_BUFFER_DEPTH);
	// One extra bit so a full buffer is distinct from an empty one
	localparam int CMD_COUNT_BITS    = CMD_PTR_BITS + 1;

	//////////////////////////////
	// Types
	//////////////////////////////

	typedef logic [CU_ID_BITS-1:0] cu_id_t;

	// What a CU presents with its request
	typedef struct packed {
		logic [ADDR_BITS-1:0] address;
		logic [SIZE_BITS-1:0] size;
	} cu_command_t;

	// Command after arbitration, stamped with its source CU
	typedef struct packed {
		logic                 valid;
		cu_id_t               cu_id;
		logic [ADDR_BITS-1:0] address;
		logic [SIZE_BITS-1:0] size;
	} read_command_t;

	// Host read response, routed back by cu_id
	typedef struct packed {
		logic                valid;
		cu_id_t              cu_id;
		logic [TAG_BITS-1:0] tag;
	} read_response_t;

endpackage
